/* Makefile */
TOP := rbb_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f logic/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* all.f */
+incdir+bench
logic/rbb_pkg.sv
logic/rbb_cmd_decoder.sv
logic/rbb_reply_tx.sv
logic/jtag_tap_ctrl.sv
logic/jtag_tap_regs.sv
logic/rbb_top.sv
bench/rbb_assertions.sv
bench/rbb_tb.sv

/* bench/rbb_assertions.sv */
`timescale 1ns/1ps

module rbb_assertions (
    input logic                clk,
    input logic                rst,
    input logic                cmd_req,
    input logic                cmd_ack,
    input logic                rsp_req,
    input logic [7:0]          rsp_data,
    input logic                rsp_ack,
    input rbb_pkg::jtag_pins_t jtag,
    input rbb_pkg::rst_pins_t  resets,
    input logic                led,
    input logic                halted
);

    // ack only ever answers a pending request
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    reply_data_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_req && $past(rsp_req) |-> $stable(rsp_data))
        else $error("rsp_data changed while rsp_req was high");

    req_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(rsp_req) |-> $past(rsp_ack))
        else $error("rsp_req dropped before rsp_ack");

    // tck low, tms and tdi high, both resets released
    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !cmd_ack && !rsp_req && jtag == 3'b011 && resets == 2'b11
                       && !led && !halted)
        else $error("outputs left their reset values right after reset");

endmodule

bind rbb_top rbb_assertions rbb_assertions_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .rsp_req  (rsp_req),
    .rsp_data (rsp_data),
    .rsp_ack  (rsp_ack),
    .jtag     (jtag),
    .resets   (resets),
    .led      (led),
    .halted   (halted)
);

/* bench/rbb_tasks.svh */
// raise a command byte and wait for the ack
// acked stays 0 on timeout
task automatic offer_cmd(input logic [7:0] data, output logic acked);
    int waited;
    cmd_data = data;
    cmd_req  = 1'b1;
    acked    = 1'b0;
    waited   = 0;
    while (!acked && waited < timeout_cycles) begin
        @(negedge clk);
        acked  = cmd_ack;
        waited = waited + 1;
    end
    cmd_req = 1'b0;
    if (acked) begin
        waited = 0;
        while (cmd_ack && waited < timeout_cycles) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (cmd_ack) begin
            fail_run("cmd_ack stayed high after cmd_req was released");
        end
    end
endtask

task automatic send_cmd(input logic [7:0] data);
    logic acked;
    offer_cmd(data, acked);
    if (!acked) begin
        fail_run($sformatf("command byte %h was never acknowledged", data));
    end
endtask

// wait for a reply byte without acking it
task automatic wait_reply();
    int waited;
    waited = 0;
    while (!rsp_req && waited < timeout_cycles) begin
        @(negedge clk);
        waited = waited + 1;
    end
    if (!rsp_req) begin
        fail_run("no reply byte arrived on the reply channel");
    end
endtask

// full four-phase cycle on the reply channel
// bit_value is the tdo level the reply carries
task automatic get_reply(output logic bit_value);
    int         waited;
    logic [7:0] data;
    wait_reply();
    data = rsp_data;
    assert (data == "0" || data == "1") else begin
        fail_run($sformatf("Error at %0t: rsp_data expected 30 or 31, got %h", $time, data));
    end
    bit_value = (data == "1");
    rsp_ack   = 1'b1;
    waited    = 0;
    while (rsp_req && waited < timeout_cycles) begin
        @(negedge clk);
        waited = waited + 1;
    end
    if (rsp_req) begin
        fail_run("rsp_req stayed high after rsp_ack was raised");
    end
    rsp_ack = 1'b0;
endtask

/* bench/rbb_tb.sv */
`timescale 1ns/1ps

module rbb_tb;

    logic                clk;
    logic                rst;
    logic                cmd_req;
    logic [7:0]          cmd_data;
    logic                cmd_ack;
    logic                rsp_req;
    logic [7:0]          rsp_data;
    logic                rsp_ack;
    rbb_pkg::jtag_pins_t jtag;
    rbb_pkg::rst_pins_t  resets;
    logic                led;
    logic                halted;
    integer              seed;
    int                  timeout_cycles = 200;
    logic [7:0]          unknown_bytes [6] = '{"x", "A", "8", 8'h00, 8'hff, "q"};

    rbb_top rbb_top_i (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_data (cmd_data),
        .cmd_ack  (cmd_ack),
        .rsp_req  (rsp_req),
        .rsp_data (rsp_data),
        .rsp_ack  (rsp_ack),
        .jtag     (jtag),
        .resets   (resets),
        .led      (led),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("Error at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    `include "rbb_tasks.svh"

    // one tck pulse as two digits with an optional read before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, input logic read,
                             output logic tdo_bit);
        send_cmd("0" + {6'd0, tms, tdi});
        if (read) begin
            send_cmd("R");
        end
        send_cmd("4" + {6'd0, tms, tdi});
        tdo_bit = 1'b0;
        if (read) begin
            get_reply(tdo_bit);
        end
    endtask

    task automatic reset_tap();
        logic unused;
        repeat (5) begin
            tck_cycle(1'b1, 1'b1, 1'b0, unused);
        end
        tck_cycle(1'b0, 1'b1, 1'b0, unused);
    endtask

    // from run-test/idle
    task automatic enter_shift_dr();
        logic unused;
        tck_cycle(1'b1, 1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b1, 1'b0, unused);
    endtask

    task automatic enter_shift_ir();
        logic unused;
        tck_cycle(1'b1, 1'b1, 1'b0, unused);
        tck_cycle(1'b1, 1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b1, 1'b0, unused);
    endtask

    // LSB first and out through update to run-test/idle
    task automatic scan_reg(input int len, input logic [31:0] tdi_bits, input logic read,
                            output logic [31:0] tdo_bits);
        int   i;
        logic bit_value;
        tdo_bits = 32'd0;
        for (i = 0; i < len; i++) begin
            tck_cycle(i == len - 1, tdi_bits[i], read, bit_value);
            tdo_bits[i] = bit_value;
        end
        tck_cycle(1'b1, 1'b1, 1'b0, bit_value);
        tck_cycle(1'b0, 1'b1, 1'b0, bit_value);
    endtask

    initial begin
        int          i;
        logic        acked;
        logic        bit_value;
        logic [31:0] captured;
        logic [7:0]  user_value;
        logic [7:0]  bypass_bits;
        rst      = 1'b1;
        cmd_req  = 1'b0;
        cmd_data = 8'd0;
        rsp_ack  = 1'b0;
        seed     = 67377;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("jtag", 32'h3, {29'd0, jtag});
        check_value("resets", 32'h3, {30'd0, resets});
        check_value("led", 32'h0, {31'd0, led});

        // pin commands
        for (i = 0; i < 8; i++) begin
            send_cmd("0" + 8'(i));
            check_value("jtag", i, {29'd0, jtag});
        end
        for (i = 0; i < 4; i++) begin
            send_cmd("r" + 8'(i));
            check_value("resets", i, {30'd0, resets});
        end
        send_cmd("B");
        check_value("led", 32'h1, {31'd0, led});
        send_cmd("b");
        check_value("led", 32'h0, {31'd0, led});
        for (i = 0; i < 6; i++) begin
            send_cmd(unknown_bytes[i]);
            check_value("jtag", 32'h7, {29'd0, jtag});
            check_value("resets", 32'h3, {30'd0, resets});
            check_value("led", 32'h0, {31'd0, led});
            check_value("halted", 32'h0, {31'd0, halted});
        end

        // IDCODE readout
        reset_tap();
        enter_shift_dr();
        scan_reg(32, 32'd0, 1'b1, captured);
        check_value("idcode", 32'h1BEEF0A5, captured);

        // USER round trip
        // IR capture reads back 0001
        enter_shift_ir();
        scan_reg(4, 32'h8, 1'b1, captured);
        check_value("ir capture", 32'h1, captured);
        user_value = 8'($random(seed));
        enter_shift_dr();
        scan_reg(8, {24'd0, user_value}, 1'b0, captured);
        enter_shift_dr();
        scan_reg(8, 32'd0, 1'b1, captured);
        check_value("user", {24'd0, user_value}, captured);

        // bypass echoes tdi one bit late
        enter_shift_ir();
        scan_reg(4, 32'hf, 1'b1, captured);
        check_value("ir capture", 32'h1, captured);
        bypass_bits = 8'($random(seed));
        enter_shift_dr();
        scan_reg(8, {24'd0, bypass_bits}, 1'b1, captured);
        check_value("bypass", {24'd0, bypass_bits[6:0], 1'b0}, captured);
        send_cmd("r");
        check_value("resets", 32'h0, {30'd0, resets});
        send_cmd("u");
        check_value("resets", 32'h3, {30'd0, resets});
        tck_cycle(1'b0, 1'b1, 1'b0, bit_value);
        enter_shift_dr();
        // all ones shifted in so tdo rests at 1 afterwards
        scan_reg(32, 32'hffffffff, 1'b1, captured);
        check_value("idcode after trst", 32'h1BEEF0A5, captured);

        // fill the read queue with replies held back
        for (i = 0; i < 255; i++) begin
            send_cmd("R");
        end
        offer_cmd("R", acked);
        check_value("cmd_ack with full read queue", 32'h0, {31'd0, acked});
        for (i = 0; i < 255; i++) begin
            get_reply(bit_value);
            check_value("queued reply", 32'h1, {31'd0, bit_value});
        end

        // a held reply keeps its byte while tdo moves underneath
        send_cmd("R");
        wait_reply();
        enter_shift_dr();
        // second falling tck in shift-DR puts idcode bit 1 (a 0) on tdo
        tck_cycle(1'b0, 1'b1, 1'b0, bit_value);
        tck_cycle(1'b0, 1'b1, 1'b0, bit_value);
        send_cmd("R");
        get_reply(bit_value);
        check_value("held reply", 32'h1, {31'd0, bit_value});
        get_reply(bit_value);
        check_value("reply after tdo change", 32'h0, {31'd0, bit_value});

        // halt
        send_cmd("Q");
        check_value("halted", 32'h1, {31'd0, halted});
        offer_cmd("1", acked);
        check_value("cmd_ack after halt", 32'h0, {31'd0, acked});

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* logic/jtag_tap_ctrl.sv */
`timescale 1ns/1ps

module jtag_tap_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  rbb_pkg::jtag_pins_t jtag,
    input  logic                trst,
    output rbb_pkg::tap_state_e state,
    output logic                tck_rise,
    output logic                tck_fall
);

    logic                tck_q;
    logic                tck_qq;
    logic                tms_q;
    rbb_pkg::tap_state_e next_state;

    // sample tck twice, tms alongside the first stage
    always_ff @(posedge clk) begin
        if (rst) begin
            tck_q  <= 1'b0;
            tck_qq <= 1'b0;
            tms_q  <= 1'b1;
        end else begin
            tck_q  <= jtag.tck;
            tck_qq <= tck_q;
            tms_q  <= jtag.tms;
        end
    end

    assign tck_rise = tck_q && !tck_qq;
    assign tck_fall = !tck_q && tck_qq;

    // 1149.1 state diagram
    always_comb begin
        case (state)
            rbb_pkg::test_logic_reset: next_state = tms_q ? rbb_pkg::test_logic_reset
                                                          : rbb_pkg::run_test_idle;
            rbb_pkg::run_test_idle:    next_state = tms_q ? rbb_pkg::select_dr_scan
                                                          : rbb_pkg::run_test_idle;
            rbb_pkg::select_dr_scan:   next_state = tms_q ? rbb_pkg::select_ir_scan
                                                          : rbb_pkg::capture_dr;
            rbb_pkg::capture_dr:       next_state = tms_q ? rbb_pkg::exit1_dr : rbb_pkg::shift_dr;
            rbb_pkg::shift_dr:         next_state = tms_q ? rbb_pkg::exit1_dr : rbb_pkg::shift_dr;
            rbb_pkg::exit1_dr:         next_state = tms_q ? rbb_pkg::update_dr : rbb_pkg::pause_dr;
            rbb_pkg::pause_dr:         next_state = tms_q ? rbb_pkg::exit2_dr : rbb_pkg::pause_dr;
            rbb_pkg::exit2_dr:         next_state = tms_q ? rbb_pkg::update_dr : rbb_pkg::shift_dr;
            rbb_pkg::update_dr:        next_state = tms_q ? rbb_pkg::select_dr_scan
                                                          : rbb_pkg::run_test_idle;
            rbb_pkg::select_ir_scan:   next_state = tms_q ? rbb_pkg::test_logic_reset
                                                          : rbb_pkg::capture_ir;
            rbb_pkg::capture_ir:       next_state = tms_q ? rbb_pkg::exit1_ir : rbb_pkg::shift_ir;
            rbb_pkg::shift_ir:         next_state = tms_q ? rbb_pkg::exit1_ir : rbb_pkg::shift_ir;
            rbb_pkg::exit1_ir:         next_state = tms_q ? rbb_pkg::update_ir : rbb_pkg::pause_ir;
            rbb_pkg::pause_ir:         next_state = tms_q ? rbb_pkg::exit2_ir : rbb_pkg::pause_ir;
            rbb_pkg::exit2_ir:         next_state = tms_q ? rbb_pkg::update_ir : rbb_pkg::shift_ir;
            default:                   next_state = tms_q ? rbb_pkg::select_dr_scan
                                                          : rbb_pkg::run_test_idle;
        endcase
    end

    // trst is asynchronous on a real part, here it acts on the next clk
    always_ff @(posedge clk) begin
        if (rst || !trst) begin
            state <= rbb_pkg::test_logic_reset;
        end else if (tck_rise) begin
            state <= next_state;
        end
    end

endmodule

/* logic/jtag_tap_regs.sv */
`timescale 1ns/1ps

module jtag_tap_regs (
    input  logic                clk,
    input  logic                rst,
    input  rbb_pkg::tap_state_e state,
    input  logic                tck_rise,
    input  logic                tck_fall,
    input  logic                tdi,
    output logic                tdo
);

    rbb_pkg::tap_instr_e ir;
    logic [3:0]          ir_shift;
    logic [31:0]         dr_shift;
    logic [7:0]          user_reg;

    // active instruction, back to idcode whenever the TAP resets
    always_ff @(posedge clk) begin
        if (rst || state == rbb_pkg::test_logic_reset) begin
            ir <= rbb_pkg::idcode;
        end else if (tck_rise && state == rbb_pkg::update_ir) begin
            ir <= rbb_pkg::tap_instr_e'(ir_shift);
        end
    end

    always_ff @(posedge clk) begin
        if (tck_rise) begin
            case (state)
                rbb_pkg::capture_ir: begin
                    ir_shift <= rbb_pkg::ir_capture;
                end
                rbb_pkg::shift_ir: begin
                    ir_shift <= {tdi, ir_shift[3:1]};
                end
                rbb_pkg::capture_dr: begin
                    case (ir)
                        rbb_pkg::idcode: dr_shift <= rbb_pkg::idcode_value;
                        rbb_pkg::user:   dr_shift <= {24'd0, user_reg};
                        default:         dr_shift <= 32'd0;
                    endcase
                end
                rbb_pkg::shift_dr: begin
                    // chain length follows the selected register
                    case (ir)
                        rbb_pkg::idcode: dr_shift      <= {tdi, dr_shift[31:1]};
                        rbb_pkg::user:   dr_shift[7:0] <= {tdi, dr_shift[7:1]};
                        default:         dr_shift[0]   <= tdi;
                    endcase
                end
                rbb_pkg::update_dr: begin
                    if (ir == rbb_pkg::user) begin
                        user_reg <= dr_shift[7:0];
                    end
                end
                default: begin
                    // nothing moves in the other states
                end
            endcase
        end
    end

    // tdo changes on the falling tck
    always_ff @(posedge clk) begin
        if (rst) begin
            tdo <= 1'b0;
        end else if (tck_fall) begin
            tdo <= (state == rbb_pkg::shift_ir) ? ir_shift[0] : dr_shift[0];
        end
    end

endmodule

/* logic/rbb_cmd_decoder.sv */
`timescale 1ns/1ps

module rbb_cmd_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_req,
    input  logic [7:0]          cmd_data,
    output logic                cmd_ack,
    input  logic                pending_full,
    output logic                read_strobe,
    output rbb_pkg::jtag_pins_t jtag,
    output rbb_pkg::rst_pins_t  resets,
    output logic                led,
    output logic                halted
);

    typedef enum logic [2:0] {
        op_pins,
        op_resets,
        op_led_on,
        op_led_off,
        op_read,
        op_quit,
        op_ignore
    } cmd_op_e;

    cmd_op_e    op;
    logic [7:0] digit_off;
    logic [7:0] reset_off;
    logic       accept;

    // offsets from the first byte of each range
    assign digit_off = cmd_data - rbb_pkg::cmd_digit_first;
    assign reset_off = cmd_data - rbb_pkg::cmd_reset_first;

    // classify the byte on the channel
    always_comb begin
        if (cmd_data >= rbb_pkg::cmd_digit_first && cmd_data <= rbb_pkg::cmd_digit_last) begin
            op = op_pins;
        end else if (cmd_data >= rbb_pkg::cmd_reset_first &&
                     cmd_data <= rbb_pkg::cmd_reset_last) begin
            op = op_resets;
        end else begin
            case (cmd_data)
                rbb_pkg::cmd_led_on: begin
                    op = op_led_on;
                end
                rbb_pkg::cmd_led_off: begin
                    op = op_led_off;
                end
                rbb_pkg::cmd_read: begin
                    op = op_read;
                end
                rbb_pkg::cmd_quit: begin
                    op = op_quit;
                end
                default: begin
                    op = op_ignore;
                end
            endcase
        end
    end

    // new request, not yet acked, and room for another read
    assign accept = cmd_req && !cmd_ack && !halted && !pending_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack     <= 1'b0;
            read_strobe <= 1'b0;
            jtag        <= rbb_pkg::jtag_reset_value;
            resets      <= rbb_pkg::rst_reset_value;
            led         <= 1'b0;
            halted      <= 1'b0;
        end else begin
            read_strobe <= 1'b0;
            if (accept) begin
                cmd_ack <= 1'b1;
                // effect lands on the same edge as the ack
                case (op)
                    op_pins: begin
                        jtag <= rbb_pkg::jtag_pins_t'(digit_off[2:0]);
                    end
                    op_resets: begin
                        resets <= rbb_pkg::rst_pins_t'(reset_off[1:0]);
                    end
                    op_led_on: begin
                        led <= 1'b1;
                    end
                    op_led_off: begin
                        led <= 1'b0;
                    end
                    op_read: begin
                        read_strobe <= 1'b1;
                    end
                    op_quit: begin
                        halted <= 1'b1;
                    end
                    default: begin
                        // accepted and dropped
                    end
                endcase
            end else if (cmd_ack && !cmd_req) begin
                // sender released, close the handshake
                cmd_ack <= 1'b0;
            end
        end
    end

endmodule

/* logic/rbb_pkg.sv */
package rbb_pkg;

    // digit commands map straight onto this order
    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
    } jtag_pins_t;

    // both active low
    typedef struct packed {
        logic trst;
        logic srst;
    } rst_pins_t;

    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr_scan,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir_scan,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_e;

    // anything not listed behaves as bypass
    typedef enum logic [3:0] {
        idcode = 4'b0001,
        user   = 4'b1000,
        bypass = 4'b1111
    } tap_instr_e;

    localparam logic [31:0] idcode_value = 32'h1BEEF0A5;
    localparam logic [3:0]  ir_capture   = 4'b0001;
    localparam logic [7:0]  max_pending  = 8'd255;

    localparam logic [7:0] reply_zero = "0";
    localparam logic [7:0] reply_one  = "1";

    // command bytes
    localparam logic [7:0] cmd_digit_first = "0";
    localparam logic [7:0] cmd_digit_last  = "7";
    localparam logic [7:0] cmd_reset_first = "r";
    localparam logic [7:0] cmd_reset_last  = "u";
    localparam logic [7:0] cmd_led_on      = "B";
    localparam logic [7:0] cmd_led_off     = "b";
    localparam logic [7:0] cmd_read        = "R";
    localparam logic [7:0] cmd_quit        = "Q";

    // idle pin levels: tck low, tms and tdi high
    localparam jtag_pins_t jtag_reset_value = 3'b011;
    localparam rst_pins_t  rst_reset_value  = 2'b11;

endpackage

/* logic/rbb_reply_tx.sv */
`timescale 1ns/1ps

module rbb_reply_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       read_strobe,
    input  logic       tdo,
    output logic       pending_full,
    output logic       rsp_req,
    output logic [7:0] rsp_data,
    input  logic       rsp_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release
    } reply_state_e;

    reply_state_e state;
    logic [7:0]   pending;
    logic         done;

    // handshake finishes when ack falls
    assign done         = (state == st_release) && !rsp_ack;
    assign rsp_req      = (state == st_request);
    assign pending_full = (pending == rbb_pkg::max_pending);

    // inc and dec together leave the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 8'd0;
        end else if (read_strobe && !done) begin
            pending <= pending + 8'd1;
        end else if (done && !read_strobe) begin
            pending <= pending - 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (pending != 8'd0) begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (rsp_ack) begin
                        state <= st_release;
                    end
                end
                default: begin
                    if (!rsp_ack) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // tdo captured as the request goes out
    always_ff @(posedge clk) begin
        if (state == st_idle && pending != 8'd0) begin
            rsp_data <= tdo ? rbb_pkg::reply_one : rbb_pkg::reply_zero;
        end
    end

endmodule

/* logic/rbb_top.sv */
`timescale 1ns/1ps

module rbb_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_req,
    input  logic [7:0]          cmd_data,
    output logic                cmd_ack,
    output logic                rsp_req,
    output logic [7:0]          rsp_data,
    input  logic                rsp_ack,
    output rbb_pkg::jtag_pins_t jtag,
    output rbb_pkg::rst_pins_t  resets,
    output logic                led,
    output logic                halted
);

    logic                read_strobe;
    logic                pending_full;
    logic                tdo;
    logic                tck_rise;
    logic                tck_fall;
    rbb_pkg::tap_state_e state;

    // bridge side
    rbb_cmd_decoder rbb_cmd_decoder_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_req      (cmd_req),
        .cmd_data     (cmd_data),
        .cmd_ack      (cmd_ack),
        .pending_full (pending_full),
        .read_strobe  (read_strobe),
        .jtag         (jtag),
        .resets       (resets),
        .led          (led),
        .halted       (halted)
    );

    rbb_reply_tx rbb_reply_tx_i (
        .clk          (clk),
        .rst          (rst),
        .read_strobe  (read_strobe),
        .tdo          (tdo),
        .pending_full (pending_full),
        .rsp_req      (rsp_req),
        .rsp_data     (rsp_data),
        .rsp_ack      (rsp_ack)
    );

    // target side, srst only leaves through the top ports
    jtag_tap_ctrl jtag_tap_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .jtag     (jtag),
        .trst     (resets.trst),
        .state    (state),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall)
    );

    jtag_tap_regs jtag_tap_regs_i (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tdi      (jtag.tdi),
        .tdo      (tdo)
    );

endmodule
